/* logic/bfp_settings.svh */
`ifndef BFP_SETTINGS_SVH
`define BFP_SETTINGS_SVH

// Block geometry.
`define BFP_BLOCK_SIZE 6

// Input mantissa and exponent widths.
`define BFP_DATA_MAN_W 8
`define BFP_DATA_EXP_W 8
`define BFP_WEIGHT_MAN_W 8
`define BFP_WEIGHT_EXP_W 8

// Products are exact, so the width is the sum of both mantissas.
`define BFP_PROD_MAN_W (`BFP_DATA_MAN_W + `BFP_WEIGHT_MAN_W)
`define BFP_PROD_EXP_W \
  (((`BFP_DATA_EXP_W > `BFP_WEIGHT_EXP_W) ? `BFP_DATA_EXP_W : `BFP_WEIGHT_EXP_W) + 1)
`define BFP_OUT_EXP_W (`BFP_PROD_EXP_W + 1)

// Tree depth and sum growth.
`define BFP_SHIFT $clog2(`BFP_BLOCK_SIZE)
`define BFP_SUM_W (`BFP_PROD_MAN_W + `BFP_SHIFT)
`define BFP_EXP_FIFO_DEPTH (`BFP_SHIFT + 2)

`endif

/* logic/bfp_pkg.sv */
`default_nettype none

`include "bfp_settings.svh"

package bfp_pkg;

  // Input side.
  typedef logic signed [`BFP_DATA_MAN_W-1:0] data_man_t;
  typedef logic signed [`BFP_WEIGHT_MAN_W-1:0] weight_man_t;
  typedef logic signed [`BFP_DATA_EXP_W-1:0] data_exp_t;
  typedef logic signed [`BFP_WEIGHT_EXP_W-1:0] weight_exp_t;

  // Pairwise products and their shared exponent.
  typedef logic signed [`BFP_PROD_MAN_W-1:0] prod_man_t;
  typedef logic signed [`BFP_PROD_EXP_W-1:0] prod_exp_t;

  // Tree sum before the block-size shift.
  typedef logic signed [`BFP_SUM_W-1:0] sum_t;

  // Result exponent after the shift is folded in.
  typedef logic signed [`BFP_OUT_EXP_W-1:0] out_exp_t;

endpackage

`default_nettype wire

/* logic/bfp_vector_mult.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfp_settings.svh"

module bfp_vector_mult import bfp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  data_man_t   m_data [`BFP_BLOCK_SIZE],
  input  data_exp_t   e_data,
  input  logic        data_valid,
  output logic        data_ready,
  input  weight_man_t m_weight [`BFP_BLOCK_SIZE],
  input  weight_exp_t e_weight,
  input  logic        weight_valid,
  output logic        weight_ready,
  output prod_man_t   prod_man [`BFP_BLOCK_SIZE],
  output prod_exp_t   prod_exp,
  output logic        man_valid,
  input  logic        man_ready,
  output logic        exp_valid,
  input  logic        exp_ready
);

  logic full_q;       // Product register holds a block.
  logic man_taken_q;  // Tree already took this block.
  logic exp_taken_q;  // FIFO already took this block.
  logic man_fire;
  logic exp_fire;
  logic man_done;
  logic exp_done;
  logic free;
  logic load;

  assign man_valid = full_q && !man_taken_q;
  assign exp_valid = full_q && !exp_taken_q;

  assign man_fire = man_valid && man_ready;
  assign exp_fire = exp_valid && exp_ready;
  assign man_done = man_taken_q || man_fire;
  assign exp_done = exp_taken_q || exp_fire;

  // Register can take a new pair once both consumers are served.
  assign free = !full_q || (man_done && exp_done);

  // Both readies rise together, only when a whole pair is waiting.
  assign load         = free && data_valid && weight_valid;
  assign data_ready   = load;
  assign weight_ready = load;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q      <= 1'b0;
      man_taken_q <= 1'b0;
      exp_taken_q <= 1'b0;
    end else if (free) begin
      full_q      <= load;
      man_taken_q <= 1'b0;
      exp_taken_q <= 1'b0;
    end else begin
      man_taken_q <= man_done;
      exp_taken_q <= exp_done;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      for (int i = 0; i < `BFP_BLOCK_SIZE; i++) begin
        prod_man[i] <= m_data[i] * m_weight[i];  // Exact signed product.
      end
      prod_exp <= prod_exp_t'(e_data) + prod_exp_t'(e_weight);
    end
  end

endmodule

`default_nettype wire

/* logic/fixed_adder_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_adder_tree #(
  parameter int IN_SIZE  = 6,
  parameter int IN_WIDTH = 16
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic signed [IN_WIDTH-1:0]                   data_in [IN_SIZE],
  input  logic                                         data_in_valid,
  output logic                                         data_in_ready,
  output logic signed [IN_WIDTH+$clog2(IN_SIZE)-1:0]   data_out,
  output logic                                         data_out_valid,
  input  logic                                         data_out_ready
);

  // A single input still gets one level so the interface keeps its latency.
  localparam int LEVELS = (IN_SIZE > 1) ? $clog2(IN_SIZE) : 1;
  localparam int PAD    = 1 << LEVELS;
  localparam int OUT_W  = IN_WIDTH + $clog2(IN_SIZE);

  logic signed [IN_WIDTH-1:0] padded [PAD];
  logic advance;  // Whole pipeline moves together.

  for (genvar i = 0; i < PAD; i++) begin : g_pad
    if (i < IN_SIZE) begin : g_in
      assign padded[i] = data_in[i];
    end else begin : g_zero
      assign padded[i] = '0;
    end
  end

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int W_IN  = IN_WIDTH + l;
    localparam int N_OUT = PAD >> (l + 1);

    logic signed [W_IN-1:0] operand [2*N_OUT];
    logic signed [W_IN:0]   node [N_OUT];   // One bit of growth per level.
    logic                   in_valid;
    logic                   valid_q;

    if (l == 0) begin : g_first
      assign operand  = padded;
      assign in_valid = data_in_valid;
    end else begin : g_next
      assign operand  = g_level[l-1].node;
      assign in_valid = g_level[l-1].valid_q;
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q <= 1'b0;
      end else if (advance) begin
        valid_q <= in_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (advance) begin
        for (int k = 0; k < N_OUT; k++) begin
          node[k] <= operand[2*k] + operand[2*k+1];
        end
      end
    end
  end

  // Stall everything only when the last stage is full and not taken.
  assign advance = !g_level[LEVELS-1].valid_q || data_out_ready;

  assign data_in_ready  = advance;
  assign data_out_valid = g_level[LEVELS-1].valid_q;
  assign data_out       = g_level[LEVELS-1].node[0][OUT_W-1:0];

endmodule

`default_nettype wire

/* logic/bfp_exp_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module bfp_exp_fifo #(
  parameter int DEPTH = 5,
  parameter int WIDTH = 9
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;  // Entries currently stored.
  logic             wr_en;
  logic             rd_en;

  assign in_ready  = count != CW'(DEPTH);
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];  // Head is visible without a read.

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

/* logic/bfp_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfp_settings.svh"

module bfp_result_stage import bfp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  sum_t      sum,
  input  logic      sum_valid,
  output logic      sum_ready,
  input  prod_exp_t fifo_exp,
  input  logic      fifo_valid,
  output logic      fifo_ready,
  output prod_man_t m_out,
  output out_exp_t  e_out,
  output logic      out_valid,
  input  logic      out_ready
);

  logic join_valid;
  logic take;     // Output register can accept this cycle.
  logic load;
  sum_t shifted;

  assign join_valid = sum_valid && fifo_valid;
  assign take       = !out_valid || out_ready;
  assign load       = take && join_valid;

  // Consume both sides on the same edge only.
  assign sum_ready  = take && fifo_valid;
  assign fifo_ready = take && sum_valid;

  // Undo the tree growth; the exponent absorbs the same amount.
  assign shifted = sum >>> `BFP_SHIFT;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= join_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_out <= shifted[`BFP_PROD_MAN_W-1:0];
      e_out <= out_exp_t'(fifo_exp) + out_exp_t'(`BFP_SHIFT);
    end
  end

endmodule

`default_nettype wire

/* logic/bfp_dot_product.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfp_settings.svh"

module bfp_dot_product import bfp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  data_man_t   m_data [`BFP_BLOCK_SIZE],
  input  data_exp_t   e_data,
  input  logic        data_valid,
  output logic        data_ready,
  input  weight_man_t m_weight [`BFP_BLOCK_SIZE],
  input  weight_exp_t e_weight,
  input  logic        weight_valid,
  output logic        weight_ready,
  output prod_man_t   m_out,
  output out_exp_t    e_out,
  output logic        out_valid,
  input  logic        out_ready
);

  prod_man_t prod_man [`BFP_BLOCK_SIZE];
  prod_exp_t prod_exp;
  logic      man_valid;
  logic      man_ready;
  logic      exp_valid;
  logic      exp_ready;

  sum_t      sum;
  logic      sum_valid;
  logic      sum_ready;
  prod_exp_t fifo_exp;  // Exponent waiting for its sum.
  logic      fifo_valid;
  logic      fifo_ready;

  bfp_vector_mult u_mult (
    .clk          (clk),
    .rst          (rst),
    .m_data       (m_data),
    .e_data       (e_data),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .m_weight     (m_weight),
    .e_weight     (e_weight),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .prod_man     (prod_man),
    .prod_exp     (prod_exp),
    .man_valid    (man_valid),
    .man_ready    (man_ready),
    .exp_valid    (exp_valid),
    .exp_ready    (exp_ready)
  );

  fixed_adder_tree #(
    .IN_SIZE  (`BFP_BLOCK_SIZE),
    .IN_WIDTH (`BFP_PROD_MAN_W)
  ) u_tree (
    .clk            (clk),
    .rst            (rst),
    .data_in        (prod_man),
    .data_in_valid  (man_valid),
    .data_in_ready  (man_ready),
    .data_out       (sum),
    .data_out_valid (sum_valid),
    .data_out_ready (sum_ready)
  );

  bfp_exp_fifo #(
    .DEPTH (`BFP_EXP_FIFO_DEPTH),
    .WIDTH (`BFP_PROD_EXP_W)
  ) u_exp_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (prod_exp),
    .in_valid  (exp_valid),
    .in_ready  (exp_ready),
    .out_data  (fifo_exp),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  bfp_result_stage u_result (
    .clk        (clk),
    .rst        (rst),
    .sum        (sum),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready),
    .fifo_exp   (fifo_exp),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .m_out      (m_out),
    .e_out      (e_out),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // Half period per toggle.
  end

endmodule

`default_nettype wire

/* bench/bfp_dot_product_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module bfp_dot_product_assert import bfp_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      data_valid,
  input logic      data_ready,
  input logic      weight_valid,
  input logic      weight_ready,
  input logic      man_valid,
  input logic      exp_valid,
  input logic      sum_valid,
  input logic      fifo_valid,
  input prod_man_t m_out,
  input out_exp_t  e_out,
  input logic      out_valid,
  input logic      out_ready
);

  int violations = 0;  // Failed assertions so far.

  // A reset cycle leaves every stream of the engine empty.
  reset_clears_valids: assert property (@(posedge clk)
    rst |=> !out_valid && !man_valid && !exp_valid && !sum_valid && !fifo_valid)
    else begin
      $error("valid high after a reset cycle");
      violations++;
    end

  // Stalled result must not change.
  out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(m_out) && $stable(e_out))
    else begin
      $error("result changed while stalled");
      violations++;
    end

  handshake_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({data_valid, data_ready, weight_valid, weight_ready, out_valid, out_ready}))
    else begin
      $error("handshake signal unknown");
      violations++;
    end

endmodule

`default_nettype wire

/* bench/tb_bfp_dot_product.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bfp_settings.svh"

module tb_bfp_dot_product import bfp_pkg::*; ();

  localparam int BLOCK          = `BFP_BLOCK_SIZE;
  localparam int SHIFT          = $clog2(`BFP_BLOCK_SIZE);
  localparam int LATENCY        = SHIFT + 2;  // Product reg, tree levels, result reg.
  localparam int N_RANDOM       = 200;
  localparam int N_PRESSURE     = 100;
  localparam int N_SKEW         = 4;
  localparam int N_EXTREME      = 5;
  localparam int N_BURST        = 50;
  localparam int TOTAL_BLOCKS   = N_RANDOM + N_PRESSURE + N_SKEW + N_EXTREME + 1 + N_BURST;
  localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * 20 + 100;

  logic        clk;
  logic        rst;
  data_man_t   m_data [BLOCK];
  data_exp_t   e_data;
  logic        data_valid;
  logic        data_ready;
  weight_man_t m_weight [BLOCK];
  weight_exp_t e_weight;
  logic        weight_valid;
  logic        weight_ready;
  prod_man_t   m_out;
  out_exp_t    e_out;
  logic        out_valid;
  logic        out_ready;

  int     ready_pct = 100;  // Chance of out_ready per cycle.
  int     cycle = 0;
  int     in_count = 0;
  int     out_count = 0;
  longint want_man_q [$];
  longint want_exp_q [$];
  int     in_cycles [$];
  int     out_cycles [$];

  tb_clock_gen #(.PERIOD_NS(20)) u_clk (.clk(clk));

  bfp_dot_product UUT (
    .clk          (clk),
    .rst          (rst),
    .m_data       (m_data),
    .e_data       (e_data),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .m_weight     (m_weight),
    .e_weight     (e_weight),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .m_out        (m_out),
    .e_out        (e_out),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  bind bfp_dot_product bfp_dot_product_assert u_assert (
    .clk(clk), .rst(rst), .data_valid(data_valid), .data_ready(data_ready),
    .weight_valid(weight_valid), .weight_ready(weight_ready),
    .man_valid(man_valid), .exp_valid(exp_valid), .sum_valid(sum_valid),
    .fifo_valid(fifo_valid), .m_out(m_out),
    .e_out(e_out), .out_valid(out_valid), .out_ready(out_ready)
  );

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic randomize_block();
    for (int i = 0; i < BLOCK; i++) begin
      m_data[i]   = data_man_t'($urandom);
      m_weight[i] = weight_man_t'($urandom);
    end
    e_data   = data_exp_t'($urandom);
    e_weight = weight_exp_t'($urandom);
  endtask

  // Even and odd lanes take separate values.
  task automatic load_pattern(input int d_even, input int d_odd, input int w_even,
                              input int w_odd, input int ed, input int ew);
    for (int i = 0; i < BLOCK; i++) begin
      m_data[i]   = data_man_t'((i % 2) ? d_odd : d_even);
      m_weight[i] = weight_man_t'((i % 2) ? w_odd : w_even);
    end
    e_data   = data_exp_t'(ed);
    e_weight = weight_exp_t'(ew);
  endtask

  // Called on a falling edge; returns on the falling edge after the transfer.
  task automatic send_block(input int data_gap, input int weight_gap);
    int n;
    n = 0;
    data_valid   = (data_gap == 0);
    weight_valid = (weight_gap == 0);
    while (!(data_valid && weight_valid)) begin
      @(negedge clk);
      n++;
      data_valid   = (n >= data_gap);
      weight_valid = (n >= weight_gap);
    end
    do begin
      @(posedge clk);
    end while (!(data_ready && weight_ready));
    @(negedge clk);
  endtask

  task automatic drain_results();
    data_valid   = 1'b0;
    weight_valid = 1'b0;
    while (want_man_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  always @(negedge clk) begin
    out_ready = ($urandom_range(99) < ready_pct);
  end

  // Monitor, model and timeout.
  always @(posedge clk) begin
    longint acc;
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d results pending", cycle, want_man_q.size());
      stop_with_failure();
    end else if (!rst) begin
      check_value("assertion failures", UUT.u_assert.violations, 0);
      check_value("weight transfer", weight_valid && weight_ready, data_valid && data_ready);
      if (!(data_valid && weight_valid)) begin
        check_value("data_ready", data_ready, 0);  // A lone valid sees no ready.
        check_value("weight_ready", weight_ready, 0);
      end
      if (data_valid && data_ready && weight_valid && weight_ready) begin
        acc = 0;
        for (int i = 0; i < BLOCK; i++) begin
          acc += longint'(m_data[i]) * longint'(m_weight[i]);  // Exact dot product.
        end
        want_man_q.push_back(acc >>> SHIFT);
        want_exp_q.push_back(longint'(e_data) + longint'(e_weight) + SHIFT);
        in_cycles.push_back(cycle);
        in_count++;
      end
      if (out_valid && out_ready) begin
        if (want_man_q.size() == 0) begin
          $display("result delivered at %0t with no block pending", $time);
          stop_with_failure();
        end else begin
          check_value("m_out", m_out, want_man_q.pop_front());
          check_value("e_out", e_out, want_exp_q.pop_front());
          out_cycles.push_back(cycle);
          out_count++;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h5a839014));
    rst          = 1'b1;
    data_valid   = 1'b0;
    weight_valid = 1'b0;
    out_ready    = 1'b0;
    load_pattern(0, 0, 0, 0, 0, 0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (N_RANDOM) begin
      randomize_block();
      send_block($urandom_range(3), $urandom_range(3));
    end
    drain_results();

    ready_pct = 30;  // Back-pressure from the output.
    repeat (N_PRESSURE) begin
      randomize_block();
      send_block($urandom_range(2), $urandom_range(2));
    end
    drain_results();
    ready_pct = 100;

    // One stream waits long for the other.
    randomize_block();
    send_block(0, 12);
    randomize_block();
    send_block(15, 0);
    randomize_block();
    send_block(0, 9);
    randomize_block();
    send_block(7, 0);
    drain_results();

    load_pattern(-128, -128, -128, -128, -128, -128);
    send_block(0, 0);
    load_pattern(127, 127, 127, 127, 127, 127);
    send_block(0, 0);
    load_pattern(100, 100, 50, -50, 5, -7);  // Lanes cancel to zero.
    send_block(0, 0);
    load_pattern(127, 127, -128, -128, 127, -128);
    send_block(0, 0);
    load_pattern(-128, 127, 1, -1, -128, 127);
    send_block(0, 0);
    drain_results();

    in_cycles.delete();
    out_cycles.delete();
    randomize_block();
    send_block(0, 0);
    drain_results();
    check_value("latency", out_cycles[0] - in_cycles[0], LATENCY);

    in_cycles.delete();
    out_cycles.delete();
    repeat (N_BURST) begin
      randomize_block();
      send_block(0, 0);
    end
    drain_results();
    check_value("burst results", out_cycles.size(), N_BURST);
    check_value("burst span", out_cycles[N_BURST-1] - out_cycles[0], N_BURST - 1);

    if (in_count == out_count && want_man_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("%0d blocks accepted but %0d results delivered", in_count, out_count);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/bfp_pkg.sv
logic/bfp_vector_mult.sv
logic/fixed_adder_tree.sv
logic/bfp_exp_fifo.sv
logic/bfp_result_stage.sv
logic/bfp_dot_product.sv
bench/tb_clock_gen.sv
bench/bfp_dot_product_assert.sv
bench/tb_bfp_dot_product.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bfp_dot_product
BUILD_DIR ?= obj_dir
FILE_LIST ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= PASS: all tests

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes.
$(SIM_BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The run passes only if the pass line shows up in the output.
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
